// ==== verilog/sdram_pkg.sv ====
// Shared definitions of the two-channel SDRAM controller
// Pin command encoding, wheel slots, address layout and data types
// Mode register value and the power-up step numbers
`default_nettype none

package sdram_pkg;

	// Commands packed as {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		INHIBIT      = 4'b1111,
		NOP          = 4'b0111,
		ACTIVE       = 4'b0011,
		READ         = 4'b0101,
		WRITE        = 4'b0100,
		PRECHARGE    = 4'b0010,
		AUTO_REFRESH = 4'b0001,
		LOAD_MODE    = 4'b0000
	} sd_cmd_t;

	// ----------------------------------------
	// Slot wheel, 12 cycles per turn
	typedef logic [3:0] slot_t;

	localparam slot_t SLOT_RAS0  = 4'd0;
	localparam slot_t SLOT_CAS0  = 4'd2;
	localparam slot_t SLOT_RAS1  = 4'd3;
	localparam slot_t SLOT_CAS1  = 4'd5;
	localparam slot_t SLOT_READ0 = 4'd6;
	localparam slot_t SLOT_READ1 = 4'd9;
	localparam slot_t SLOT_LAST  = 4'd11;

	// Word address, bank on top
	typedef struct packed {
		logic [1:0]  bank;
		logic [12:0] row;
		logic [8:0]  col;
	} sd_addr_t;

	typedef logic [15:0] word_t;
	// Byte enables, 1 means the byte takes part
	typedef logic [1:0] mask_t;

	// Port of a channel that owns the current access
	typedef enum logic [1:0] {
		SRC_NONE = 2'd0,
		SRC_REQ  = 2'd1,
		SRC_RO   = 2'd2
	} src_t;

	// ----------------------------------------
	localparam logic [2:0] CAS_LATENCY = 3'd2;

	// Burst 1, sequential, standard operation, single-word write
	localparam logic [12:0] MODE_WORD = {3'b000, 1'b1, 2'b00, CAS_LATENCY, 1'b0, 3'b000};

	// Power-up countdown, one step per wheel turn
	localparam logic [4:0] INIT_TURNS          = 5'd31;
	localparam logic [4:0] INIT_PRECHARGE_STEP = 5'd15;
	localparam logic [4:0] INIT_REFRESH_STEP0  = 5'd10;
	localparam logic [4:0] INIT_REFRESH_STEP1  = 5'd8;
	localparam logic [4:0] INIT_MODE_STEP      = 5'd2;

endpackage

`default_nettype wire

// ==== verilog/sdram_chan_if.sv ====
// Channel link between a port arbiter and the command sequencer
// Proposal from the arbiter, completion from the sequencer
`timescale 1ns/100ps
`default_nettype none

interface sdram_chan_if;
	import sdram_pkg::*;

	// Proposed access, held while busy
	src_t     src;
	sd_addr_t addr;
	mask_t    mask;
	logic     we;
	word_t    din;
	logic     busy;

	// One-cycle completion pulse and read word
	logic     done;
	src_t     done_src;
	word_t    rdata;

	modport arbiter (
		output src, addr, mask, we, din, busy,
		input  done, done_src, rdata
	);

	modport seq (
		input  src, addr, mask, we, din, busy,
		output done, done_src, rdata
	);

endinterface

`default_nettype wire

// ==== verilog/sdram_slot_timer.sv ====
// Slot wheel of the SDRAM controller
// 12-state position counter and power-up step countdown
`timescale 1ns/100ps
`default_nettype none

module sdram_slot_timer (
	input  wire              clk,
	input  wire              init_n,
	output sdram_pkg::slot_t slot,
	output logic             init_busy,
	output logic [4:0]       init_step
);
	import sdram_pkg::*;

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			slot      <= SLOT_RAS0;
			init_step <= INIT_TURNS;
			init_busy <= 1'b1;
		end else begin
			// Wheel wraps after the last slot
			if (slot == SLOT_LAST)
				slot <= SLOT_RAS0;
			else
				slot <= slot + 4'd1;
			// One countdown step per turn, stops at zero
			if (slot == SLOT_LAST && init_step != 5'd0)
				init_step <= init_step - 5'd1;
			init_busy <= (init_step != 5'd0);
		end
	end

	a_slot_range: assert property (@(posedge clk) disable iff (!init_n)
		slot <= SLOT_LAST)
		else $error("Slot wheel left its range");

endmodule

`default_nettype wire

// ==== verilog/sdram_chan_arbiter.sv ====
// Port arbiter of one SDRAM channel
// Fixed priority of the toggle port over the read-only port
// Toggle state tracking, held proposal and result registers
`timescale 1ns/100ps
`default_nettype none

module sdram_chan_arbiter #(
	parameter bit BANK_HI  = 1'b0,
	parameter bit RO_LEVEL = 1'b0
) (
	input  wire                  clk,
	input  wire                  init_n,
	input  wire sdram_pkg::slot_t slot,
	input  wire                  rw_req,
	input  wire                  rw_we,
	input  wire sdram_pkg::sd_addr_t rw_addr,
	input  wire sdram_pkg::mask_t rw_mask,
	input  wire sdram_pkg::word_t rw_d,
	output logic                 rw_ack,
	output sdram_pkg::word_t     rw_q,
	input  wire                  ro_req,
	input  wire sdram_pkg::sd_addr_t ro_addr,
	output logic                 ro_done,
	output sdram_pkg::word_t     ro_q,
	sdram_chan_if.arbiter        chan
);
	import sdram_pkg::*;

	// Row slot of this channel
	localparam slot_t RAS_SLOT = BANK_HI ? SLOT_RAS1 : SLOT_RAS0;

	logic     rw_state;
	logic     ro_state;
	logic     ro_flag;
	logic     busy;
	logic     rw_pend;
	logic     ro_pend;
	logic     take;
	src_t     pick_src;
	sd_addr_t pick_addr;
	mask_t    pick_mask;
	logic     pick_we;
	src_t     h_src;
	sd_addr_t h_addr;
	mask_t    h_mask;
	logic     h_we;
	word_t    h_din;

	// Toggle port pends on req != state, level port on cs && !valid
	assign rw_pend = (rw_req != rw_state);
	assign ro_pend = RO_LEVEL ? (ro_req && !ro_flag) : (ro_req != ro_state);

	always_comb begin
		pick_src  = SRC_NONE;
		pick_addr = rw_addr;
		pick_mask = 2'b11;
		pick_we   = 1'b0;
		if (rw_pend) begin
			pick_src  = SRC_REQ;
			pick_mask = rw_mask;
			pick_we   = rw_we;
		end else if (ro_pend) begin
			pick_src  = SRC_RO;
			pick_addr = ro_addr;
		end
		// Channel owns one half of the banks
		pick_addr.bank[1] = BANK_HI;
	end

	// Winner is latched in the row slot and held until done
	assign take = (slot == RAS_SLOT) && !busy && (pick_src != SRC_NONE);

	// Held access is offered again if the row slot was refused
	assign chan.src  = busy ? h_src : pick_src;
	assign chan.addr = busy ? h_addr : pick_addr;
	assign chan.mask = busy ? h_mask : pick_mask;
	assign chan.we   = busy ? h_we : pick_we;
	assign chan.din  = busy ? h_din : rw_d;
	assign chan.busy = busy;

	assign ro_done = ro_flag;

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			busy     <= 1'b0;
			h_src    <= SRC_NONE;
			rw_state <= 1'b0;
			ro_state <= 1'b0;
			rw_ack   <= 1'b0;
			ro_flag  <= 1'b0;
		end else begin
			if (take) begin
				busy  <= 1'b1;
				h_src <= pick_src;
				if (pick_src == SRC_REQ)
					rw_state <= rw_req;
				else
					ro_state <= ro_req;
			end
			if (chan.done) begin
				busy <= 1'b0;
				if (chan.done_src == SRC_REQ)
					rw_ack <= rw_state;
				else if (RO_LEVEL)
					ro_flag <= 1'b1;
				else
					ro_flag <= ro_state;
			end else if (RO_LEVEL && !ro_req) begin
				// valid drops once cs is released
				ro_flag <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			h_addr <= pick_addr;
			h_mask <= pick_mask;
			h_we   <= pick_we;
			h_din  <= rw_d;
		end
		if (chan.done && chan.done_src == SRC_REQ && !h_we)
			rw_q <= chan.rdata;
		if (chan.done && chan.done_src == SRC_RO)
			ro_q <= chan.rdata;
	end

	// Completion only for the access this arbiter holds
	a_done_owned: assert property (@(posedge clk) disable iff (!init_n)
		chan.done |-> busy && chan.src != SRC_NONE && chan.done_src == chan.src)
		else $error("done without a held access");

endmodule

`default_nettype wire

// ==== verilog/sdram_cmd_seq.sv ====
// Command sequencer of the SDRAM controller
// Power-up commands, row and column commands of both channels
// Refresh counter, registered pins and read data capture
`timescale 1ns/100ps
`default_nettype none

module sdram_cmd_seq #(
	parameter int MHZ = 80
) (
	input  wire                   clk,
	input  wire                   init_n,
	input  wire sdram_pkg::slot_t slot,
	input  wire                   init_busy,
	input  wire [4:0]             init_step,
	input  wire sdram_pkg::word_t dq_in,
	sdram_chan_if.seq             ch0,
	sdram_chan_if.seq             ch1,
	output sdram_pkg::sd_cmd_t    cmd,
	output logic [12:0]           a,
	output logic [1:0]            ba,
	output logic [1:0]            dqm,
	output sdram_pkg::word_t      dq_out,
	output logic                  dq_oe
);
	import sdram_pkg::*;

	// 7.8 us between refreshes
	localparam logic [10:0] RFRSH_CYCLES = 11'(78 * MHZ / 10);

	localparam slot_t [1:0] RAS_SLOT  = {SLOT_RAS1, SLOT_RAS0};
	localparam slot_t [1:0] CAS_SLOT  = {SLOT_CAS1, SLOT_CAS0};
	localparam slot_t [1:0] READ_SLOT = {SLOT_READ1, SLOT_READ0};

	src_t     p_src [2];
	sd_addr_t p_addr [2];
	mask_t    p_mask [2];
	logic     p_we [2];
	word_t    p_din [2];

	// Per channel access latched in the row slot
	logic [1:0] act;
	logic [1:0] accept;
	src_t       lat_src [2];
	sd_addr_t   lat_addr [2];
	mask_t      lat_mask [2];
	logic [1:0] lat_we;
	word_t      lat_din [2];

	logic [10:0] refresh_cnt;
	logic        need_refresh;
	logic        refresh_now;
	logic        refresh_blk;
	word_t       sd_din;

	sd_cmd_t     cmd_nxt;
	logic [12:0] a_nxt;
	logic [1:0]  ba_nxt;
	logic [1:0]  dqm_nxt;
	logic        oe_nxt;
	word_t       dout_nxt;

	assign p_src[0]  = ch0.src;
	assign p_src[1]  = ch1.src;
	assign p_addr[0] = ch0.addr;
	assign p_addr[1] = ch1.addr;
	assign p_mask[0] = ch0.mask;
	assign p_mask[1] = ch1.mask;
	assign p_we[0]   = ch0.we;
	assign p_we[1]   = ch1.we;
	assign p_din[0]  = ch0.din;
	assign p_din[1]  = ch1.din;

	// Channel 0 sits out one turn after a refresh
	assign accept[0] = !init_busy && slot == SLOT_RAS0 && p_src[0] != SRC_NONE && !refresh_blk;
	assign accept[1] = !init_busy && slot == SLOT_RAS1 && p_src[1] != SRC_NONE;

	assign need_refresh = (refresh_cnt >= RFRSH_CYCLES);
	// Refresh only with both channels quiet
	assign refresh_now = !init_busy && slot == SLOT_RAS1 && p_src[1] == SRC_NONE
		&& !ch0.busy && !act[0] && need_refresh;

	// Writes finish at CAS, reads at the capture slot
	assign ch0.done     = act[0] && slot == (lat_we[0] ? CAS_SLOT[0] : READ_SLOT[0]);
	assign ch1.done     = act[1] && slot == (lat_we[1] ? CAS_SLOT[1] : READ_SLOT[1]);
	assign ch0.done_src = lat_src[0];
	assign ch1.done_src = lat_src[1];
	assign ch0.rdata    = sd_din;
	assign ch1.rdata    = sd_din;

	// ----------------------------------------
	// Next pin state, registered below
	always_comb begin
		cmd_nxt  = NOP;
		a_nxt    = a;
		ba_nxt   = ba;
		dqm_nxt  = 2'b11;
		oe_nxt   = 1'b0;
		dout_nxt = dq_out;
		if (init_busy) begin
			if (slot == SLOT_RAS0) begin
				if (init_step == INIT_PRECHARGE_STEP) begin
					// A10 high closes all banks
					cmd_nxt = PRECHARGE;
					a_nxt   = 13'h0400;
				end
				if (init_step == INIT_REFRESH_STEP0 || init_step == INIT_REFRESH_STEP1)
					cmd_nxt = AUTO_REFRESH;
				if (init_step == INIT_MODE_STEP) begin
					cmd_nxt = LOAD_MODE;
					a_nxt   = MODE_WORD;
					ba_nxt  = 2'b00;
				end
			end
		end else begin
			for (int c = 0; c < 2; c++) begin
				if (accept[c]) begin
					cmd_nxt = ACTIVE;
					a_nxt   = p_addr[c].row;
					ba_nxt  = p_addr[c].bank;
				end
				if (slot == CAS_SLOT[c] && act[c]) begin
					cmd_nxt = lat_we[c] ? WRITE : READ;
					// A10 set for auto-precharge
					a_nxt   = {4'b0010, lat_addr[c].col};
					ba_nxt  = lat_addr[c].bank;
					dqm_nxt = ~lat_mask[c];
					if (lat_we[c]) begin
						oe_nxt   = 1'b1;
						dout_nxt = lat_din[c];
					end
				end
			end
			if (refresh_now)
				cmd_nxt = AUTO_REFRESH;
		end
	end

	// ----------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			cmd         <= NOP;
			dqm         <= 2'b11;
			dq_oe       <= 1'b0;
			act         <= 2'b00;
			lat_src     <= '{SRC_NONE, SRC_NONE};
			refresh_cnt <= 11'd0;
			refresh_blk <= 1'b0;
		end else begin
			cmd   <= cmd_nxt;
			dqm   <= dqm_nxt;
			dq_oe <= oe_nxt;
			for (int c = 0; c < 2; c++) begin
				if (slot == RAS_SLOT[c])
					act[c] <= accept[c];
				if (accept[c])
					lat_src[c] <= p_src[c];
			end
			// Counter saturates until the refresh goes out
			if (refresh_now)
				refresh_cnt <= 11'd0;
			else if (!need_refresh)
				refresh_cnt <= refresh_cnt + 11'd1;
			if (slot == SLOT_RAS1)
				refresh_blk <= refresh_now;
		end
	end

	always_ff @(posedge clk) begin
		a      <= a_nxt;
		ba     <= ba_nxt;
		dq_out <= dout_nxt;
		// Read word lands two cycles after READ, used in the next slot
		sd_din <= dq_in;
		for (int c = 0; c < 2; c++) begin
			if (accept[c]) begin
				lat_addr[c] <= p_addr[c];
				lat_mask[c] <= p_mask[c];
				lat_we[c]   <= p_we[c];
				lat_din[c]  <= p_din[c];
			end
		end
	end

	a_oe_write: assert property (@(posedge clk) disable iff (!init_n)
		dq_oe |-> cmd == WRITE && $past(slot == SLOT_CAS0 || slot == SLOT_CAS1))
		else $error("dq_oe outside a WRITE");

endmodule

`default_nettype wire

// ==== verilog/sdram_2ch.sv ====
// Two-channel SDR SDRAM controller, top level
// Slot timer, one arbiter per channel and the command sequencer
// Channel 0 serves port1 and rom, channel 1 serves port2 and gfx
`timescale 1ns/100ps
`default_nettype none

module sdram_2ch #(
	parameter int MHZ = 80
) (
	input  wire                      clk,
	input  wire                      init_n,
	// Channel 0, banks 0 and 1
	input  wire                      port1_req,
	output wire                      port1_ack,
	input  wire                      port1_we,
	input  wire sdram_pkg::sd_addr_t port1_addr,
	input  wire sdram_pkg::mask_t    port1_mask,
	input  wire sdram_pkg::word_t    port1_d,
	output wire sdram_pkg::word_t    port1_q,
	input  wire                      rom_cs,
	input  wire sdram_pkg::sd_addr_t rom_addr,
	output wire                      rom_valid,
	output wire sdram_pkg::word_t    rom_q,
	// Channel 1, banks 2 and 3
	input  wire                      port2_req,
	output wire                      port2_ack,
	input  wire                      port2_we,
	input  wire sdram_pkg::sd_addr_t port2_addr,
	input  wire sdram_pkg::mask_t    port2_mask,
	input  wire sdram_pkg::word_t    port2_d,
	output wire sdram_pkg::word_t    port2_q,
	input  wire                      gfx_req,
	output wire                      gfx_ack,
	input  wire sdram_pkg::sd_addr_t gfx_addr,
	output wire sdram_pkg::word_t    gfx_q,
	// SDRAM pins, data bus split for an outside tristate
	output wire                      sd_cs_n,
	output wire                      sd_ras_n,
	output wire                      sd_cas_n,
	output wire                      sd_we_n,
	output wire [12:0]               sd_a,
	output wire [1:0]                sd_ba,
	output wire [1:0]                sd_dqm,
	input  wire sdram_pkg::word_t    dq_in,
	output wire sdram_pkg::word_t    dq_out,
	output wire                      dq_oe
);
	import sdram_pkg::*;

	slot_t      slot;
	logic       init_busy;
	logic [4:0] init_step;
	sd_cmd_t    sd_cmd;

	sdram_chan_if ch0_if ();
	sdram_chan_if ch1_if ();

	assign {sd_cs_n, sd_ras_n, sd_cas_n, sd_we_n} = sd_cmd;

	sdram_slot_timer u_slot_timer (
		.clk       (clk),
		.init_n    (init_n),
		.slot      (slot),
		.init_busy (init_busy),
		.init_step (init_step)
	);

	// rom uses the level cs/valid style
	sdram_chan_arbiter #(.BANK_HI(1'b0), .RO_LEVEL(1'b1)) u_arb0 (
		.clk (clk), .init_n (init_n), .slot (slot),
		.rw_req (port1_req), .rw_we (port1_we), .rw_addr (port1_addr),
		.rw_mask (port1_mask), .rw_d (port1_d), .rw_ack (port1_ack), .rw_q (port1_q),
		.ro_req (rom_cs), .ro_addr (rom_addr), .ro_done (rom_valid), .ro_q (rom_q),
		.chan (ch0_if.arbiter)
	);

	// gfx uses the toggle req/ack style
	sdram_chan_arbiter #(.BANK_HI(1'b1), .RO_LEVEL(1'b0)) u_arb1 (
		.clk (clk), .init_n (init_n), .slot (slot),
		.rw_req (port2_req), .rw_we (port2_we), .rw_addr (port2_addr),
		.rw_mask (port2_mask), .rw_d (port2_d), .rw_ack (port2_ack), .rw_q (port2_q),
		.ro_req (gfx_req), .ro_addr (gfx_addr), .ro_done (gfx_ack), .ro_q (gfx_q),
		.chan (ch1_if.arbiter)
	);

	sdram_cmd_seq #(.MHZ(MHZ)) u_cmd_seq (
		.clk       (clk),
		.init_n    (init_n),
		.slot      (slot),
		.init_busy (init_busy),
		.init_step (init_step),
		.dq_in     (dq_in),
		.ch0       (ch0_if.seq),
		.ch1       (ch1_if.seq),
		.cmd       (sd_cmd),
		.a         (sd_a),
		.ba        (sd_ba),
		.dqm       (sd_dqm),
		.dq_out    (dq_out),
		.dq_oe     (dq_oe)
	);

endmodule

`default_nettype wire

// ==== tb/sdram_model.sv ====
// Behavioral model of a 16-bit, 4-bank SDR SDRAM
// CAS latency 2 reads, byte-masked writes, bus resolution from dq_oe
// Log of every issued command with its address and cycle number
`timescale 1ns/100ps
`default_nettype none

module sdram_model (
	input  wire                     clk,
	input  wire                     enable,
	input  wire                     cs_n,
	input  wire                     ras_n,
	input  wire                     cas_n,
	input  wire                     we_n,
	input  wire [12:0]              a,
	input  wire [1:0]               ba,
	input  wire [1:0]               dqm,
	input  wire sdram_pkg::word_t   dq_out,
	input  wire                     dq_oe,
	output sdram_pkg::word_t        dq_in
);
	import sdram_pkg::*;

	// Reduced array, 4 row bits and 6 column bits per bank
	word_t       mem [4096];
	logic [12:0] open_row [4];
	sd_cmd_t     cmd;
	logic [11:0] idx;

	// Read pipeline, fetched at READ and driven one cycle later
	word_t       rd_word;
	word_t       rd_drive;
	logic        rd_pend = 1'b0;
	logic        rd_oe = 1'b0;

	// Command log
	sd_cmd_t     log_cmd [$];
	logic [12:0] log_a [$];
	logic [1:0]  log_ba [$];
	int          log_cycle [$];
	int          cycle = 0;

	assign cmd = sd_cmd_t'({cs_n, ras_n, cas_n, we_n});
	assign idx = {ba, open_row[ba][3:0], a[5:0]};

	// Controller drives the bus on writes, the model on read data
	assign dq_in = dq_oe ? dq_out : (rd_oe ? rd_drive : 16'h0000);

	always @(posedge clk) begin
		cycle++;
		rd_oe    <= rd_pend;
		rd_drive <= rd_word;
		rd_pend  <= 1'b0;
		if (enable && !cs_n && cmd != NOP) begin
			log_cmd.push_back(cmd);
			log_a.push_back(a);
			log_ba.push_back(ba);
			log_cycle.push_back(cycle);
		end
		if (enable) begin
			case (cmd)
				ACTIVE: open_row[ba] <= a;
				READ: begin
					rd_word <= mem[idx];
					rd_pend <= 1'b1;
				end
				WRITE: begin
					// dqm low lets the byte through
					if (!dqm[1])
						mem[idx][15:8] <= dq_out[15:8];
					if (!dqm[0])
						mem[idx][7:0] <= dq_out[7:0];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_sdram_2ch.sv ====
// Testbench of the two-channel SDRAM controller
// Clock, reset, stimulus table with shadow memory prediction
// Power-up, access, byte mask, read-only port, refresh and contention checks
// Watchdog and closing error summary
`timescale 1ns/100ps
`default_nettype none

module tb_sdram_2ch;
	import sdram_pkg::*;

	localparam logic [31:0] SEED = 32'h6d47_b285;
	localparam int PERIOD_NS     = 4;
	localparam int RESET_CYCLES  = 16;
	localparam int TB_MHZ        = 10;
	// 31 wheel turns of 12 cycles, plus slack
	localparam int POWER_UP_WAIT = 372 + 24;
	localparam int MAX_LATENCY   = 36;
	localparam int REFRESH_GAP   = 78 * TB_MHZ / 10 + 12;
	localparam int IDLE_CYCLES   = 300;
	localparam int NUM_STEPS     = 15;
	localparam int MEM_WORDS     = 4096;
	// Burst 1, sequential, CL 2, standard mode, single-word write
	localparam logic [12:0] EXP_MODE = 13'h0220;
	localparam int WATCHDOG_CYCLES =
		2 * (RESET_CYCLES + POWER_UP_WAIT + (NUM_STEPS + 3) * MAX_LATENCY + IDLE_CYCLES);

	localparam logic [1:0] P_PORT1 = 2'd0;
	localparam logic [1:0] P_PORT2 = 2'd1;
	localparam logic [1:0] P_ROM   = 2'd2;
	localparam logic [1:0] P_GFX   = 2'd3;

	typedef struct packed {
		logic [1:0]  port;
		logic        we;
		logic [23:0] addr;
		logic [1:0]  mask;
	} step_t;

	logic     clk;
	logic     init_n;
	logic     port1_req;
	logic     port1_ack;
	logic     port1_we;
	sd_addr_t port1_addr;
	mask_t    port1_mask;
	word_t    port1_d;
	word_t    port1_q;
	logic     port2_req;
	logic     port2_ack;
	logic     port2_we;
	sd_addr_t port2_addr;
	mask_t    port2_mask;
	word_t    port2_d;
	word_t    port2_q;
	logic     rom_cs;
	sd_addr_t rom_addr;
	logic     rom_valid;
	word_t    rom_q;
	logic     gfx_req;
	logic     gfx_ack;
	sd_addr_t gfx_addr;
	word_t    gfx_q;
	logic     sd_cs_n;
	logic     sd_ras_n;
	logic     sd_cas_n;
	logic     sd_we_n;
	logic [12:0] sd_a;
	logic [1:0]  sd_ba;
	logic [1:0]  sd_dqm;
	word_t    dq_in;
	word_t    dq_out;
	logic     dq_oe;

	step_t    tbl [NUM_STEPS];
	word_t    tbl_d [NUM_STEPS];
	word_t    shadow [MEM_WORDS];
	int       errors;
	int       checks;
	int       idle_start;

	sdram_2ch #(.MHZ(TB_MHZ)) u_sdram_2ch (.*);

	sdram_model u_model (
		.clk    (clk),
		.enable (init_n),
		.cs_n   (sd_cs_n),
		.ras_n  (sd_ras_n),
		.cas_n  (sd_cas_n),
		.we_n   (sd_we_n),
		.a      (sd_a),
		.ba     (sd_ba),
		.dqm    (sd_dqm),
		.dq_out (dq_out),
		.dq_oe  (dq_oe),
		.dq_in  (dq_in)
	);

	always #(PERIOD_NS / 2) clk = ~clk;

	// ----------------------------------------
	// Check helpers

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic require_cond(input bit cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s", msg);
		end
	endtask

	// Model index, bank with low row and column bits
	function automatic int mem_index(input logic [23:0] addr);
		return int'({addr[23:22], addr[12:9], addr[5:0]});
	endfunction

	// Preload pattern over all twelve index bits
	function automatic word_t fill_word(input int idx);
		logic [11:0] v;
		v = idx[11:0];
		return {v[3:0] ^ v[11:8], v} ^ 16'h6b2d;
	endfunction

	function automatic bit access_done(input logic [1:0] port);
		case (port)
			P_PORT1: return port1_ack == port1_req;
			P_PORT2: return port2_ack == port2_req;
			P_ROM:   return rom_valid;
			default: return gfx_ack == gfx_req;
		endcase
	endfunction

	// ----------------------------------------
	// Stimulus table

	task automatic set_step(input int i, input logic [1:0] port, input bit we,
		input int bank, input int row, input int col, input logic [1:0] mask);
		tbl[i].port = port;
		tbl[i].we   = we;
		tbl[i].addr = {2'(bank), 13'(row), 9'(col)};
		tbl[i].mask = mask;
		tbl_d[i]    = 16'($urandom());
	endtask

	task automatic build_table();
		// port1 write and read back, then a high-byte write
		set_step(0, P_PORT1, 1, 0, 1, 5, 2'b11);
		set_step(1, P_PORT1, 0, 0, 1, 5, 2'b11);
		// port2 full write, low-byte write, full read
		set_step(2, P_PORT2, 1, 2, 3, 7, 2'b11);
		set_step(3, P_PORT2, 1, 2, 3, 7, 2'b01);
		set_step(4, P_PORT2, 0, 2, 3, 7, 2'b11);
		set_step(5, P_PORT1, 1, 0, 1, 5, 2'b10);
		set_step(6, P_PORT1, 0, 0, 1, 5, 2'b11);
		// Read-only ports on preloaded and written words
		set_step(7, P_ROM, 0, 0, 4, 10, 2'b11);
		set_step(8, P_ROM, 0, 1, 5, 20, 2'b11);
		set_step(9, P_ROM, 0, 0, 1, 5, 2'b11);
		set_step(10, P_GFX, 0, 3, 6, 30, 2'b11);
		set_step(11, P_GFX, 0, 2, 3, 7, 2'b11);
		set_step(12, P_PORT2, 1, 3, 7, 40, 2'b11);
		set_step(13, P_GFX, 0, 3, 7, 40, 2'b11);
		set_step(14, P_PORT2, 0, 3, 6, 30, 2'b11);
	endtask

	task automatic preload_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = fill_word(i);
			u_model.mem[i] = fill_word(i);
		end
	endtask

	// ----------------------------------------
	// One access, wait for completion, predict and compare

	task automatic apply_step(input int i);
		int    idx;
		int    cycles;
		word_t old;
		word_t exp;
		idx = mem_index(tbl[i].addr);
		exp = shadow[idx];
		cycles = 0;
		@(negedge clk);
		case (tbl[i].port)
			P_PORT1: begin
				port1_we   = tbl[i].we;
				port1_addr = tbl[i].addr;
				port1_mask = tbl[i].mask;
				port1_d    = tbl_d[i];
				port1_req  = !port1_req;
			end
			P_PORT2: begin
				port2_we   = tbl[i].we;
				port2_addr = tbl[i].addr;
				port2_mask = tbl[i].mask;
				port2_d    = tbl_d[i];
				port2_req  = !port2_req;
			end
			P_ROM: begin
				rom_addr = tbl[i].addr;
				rom_cs   = 1'b1;
			end
			default: begin
				gfx_addr = tbl[i].addr;
				gfx_req  = !gfx_req;
			end
		endcase
		do begin
			@(negedge clk);
			cycles++;
		end while (!access_done(tbl[i].port));
		require_cond(cycles <= MAX_LATENCY,
			$sformatf("Access %0d took %0d cycles", i, cycles));
		if (tbl[i].we) begin
			// Unmasked bytes keep their old value
			old = shadow[idx];
			shadow[idx] = {tbl[i].mask[1] ? tbl_d[i][15:8] : old[15:8],
				tbl[i].mask[0] ? tbl_d[i][7:0] : old[7:0]};
		end else begin
			case (tbl[i].port)
				P_PORT1: compare_word("port1_q", port1_q, exp);
				P_PORT2: compare_word("port2_q", port2_q, exp);
				P_ROM:   compare_word("rom_q", rom_q, exp);
				default: compare_word("gfx_q", gfx_q, exp);
			endcase
		end
		if (tbl[i].port == P_ROM) begin
			rom_cs = 1'b0;
			@(negedge clk);
			require_cond(!rom_valid, "rom_valid stayed high after cs fell");
		end
	endtask

	// ----------------------------------------
	// port1 and rom requested together

	task automatic run_contention();
		sd_addr_t p1_at_addr;
		sd_addr_t rom_at_addr;
		word_t    p1_exp;
		word_t    rom_exp;
		logic     prev_ack;
		logic     prev_valid;
		int       ack_changes;
		int       valid_rises;
		int       p1_at;
		int       rom_at;
		int       cycles;
		int       settle;
		p1_at_addr  = tbl[1].addr;
		rom_at_addr = tbl[8].addr;
		p1_exp      = shadow[mem_index(p1_at_addr)];
		rom_exp     = shadow[mem_index(rom_at_addr)];
		ack_changes = 0;
		valid_rises = 0;
		p1_at       = 0;
		rom_at      = 0;
		cycles      = 0;
		settle      = 0;
		@(negedge clk);
		port1_we   = 1'b0;
		port1_addr = p1_at_addr;
		port1_mask = 2'b11;
		port1_req  = !port1_req;
		rom_addr   = rom_at_addr;
		rom_cs     = 1'b1;
		prev_ack   = port1_ack;
		prev_valid = rom_valid;
		// Watch both strobes, then a quiet window after cs falls
		while (settle < MAX_LATENCY) begin
			@(negedge clk);
			cycles++;
			if (port1_ack != prev_ack) begin
				ack_changes++;
				if (p1_at == 0)
					p1_at = cycles;
			end
			if (rom_valid && !prev_valid) begin
				valid_rises++;
				if (rom_at == 0)
					rom_at = cycles;
			end
			prev_ack   = port1_ack;
			prev_valid = rom_valid;
			if (p1_at != 0 && rom_at != 0) begin
				rom_cs = 1'b0;
				settle++;
			end
		end
		require_cond(p1_at < rom_at, "rom was served ahead of port1");
		compare_word("port1_q", port1_q, p1_exp);
		compare_word("rom_q", rom_q, rom_exp);
		require_cond(ack_changes == 1,
			$sformatf("port1_ack changed %0d times for one request", ack_changes));
		require_cond(valid_rises == 1,
			$sformatf("rom_valid rose %0d times for one request", valid_rises));
		require_cond(!rom_valid, "rom_valid stayed high after cs fell");
	endtask

	// ----------------------------------------
	// Command log checks

	task automatic power_up_order();
		int load_at;
		load_at = -1;
		require_cond(u_model.log_cmd.size() >= 4, "Fewer than four commands during power-up");
		if (u_model.log_cmd.size() >= 4) begin
			compare_word("sd_cmd", 16'(u_model.log_cmd[0]), 16'(PRECHARGE));
			compare_word("sd_a[10]", 16'(u_model.log_a[0][10]), 16'h0001);
			compare_word("sd_cmd", 16'(u_model.log_cmd[1]), 16'(AUTO_REFRESH));
			compare_word("sd_cmd", 16'(u_model.log_cmd[2]), 16'(AUTO_REFRESH));
			compare_word("sd_cmd", 16'(u_model.log_cmd[3]), 16'(LOAD_MODE));
			compare_word("sd_a", 16'(u_model.log_a[3]), 16'(EXP_MODE));
		end
		for (int i = 0; i < u_model.log_cmd.size(); i++) begin
			if (load_at < 0 && u_model.log_cmd[i] == LOAD_MODE)
				load_at = i;
		end
		require_cond(load_at >= 0, "No LOAD_MODE command during power-up");
		for (int i = 0; i < load_at; i++)
			require_cond(u_model.log_cmd[i] != ACTIVE, "ACTIVE issued before LOAD_MODE");
	endtask

	task automatic refresh_spacing(input int first);
		int last;
		int count;
		last  = -1;
		count = 0;
		for (int i = first; i < u_model.log_cmd.size(); i++) begin
			if (u_model.log_cmd[i] == AUTO_REFRESH) begin
				if (last >= 0)
					require_cond(u_model.log_cycle[i] - last <= REFRESH_GAP,
						$sformatf("Refresh gap of %0d cycles", u_model.log_cycle[i] - last));
				last = u_model.log_cycle[i];
				count++;
			end
		end
		require_cond(count >= 3, $sformatf("Only %0d refreshes while idle", count));
	endtask

	// No refresh between an ACTIVE and its column command
	task automatic refresh_placement();
		logic [3:0] row_open;
		row_open = 4'b0000;
		for (int i = 0; i < u_model.log_cmd.size(); i++) begin
			case (u_model.log_cmd[i])
				ACTIVE: row_open[u_model.log_ba[i]] = 1'b1;
				READ, WRITE: row_open[u_model.log_ba[i]] = 1'b0;
				AUTO_REFRESH: require_cond(row_open == 4'b0000,
					$sformatf("Refresh at cycle %0d with a row open", u_model.log_cycle[i]));
				default: ;
			endcase
		end
	endtask

	// ----------------------------------------
	// Main sequence

	initial begin
		errors     = 0;
		checks     = 0;
		clk        = 1'b0;
		init_n     = 1'b0;
		port1_req  = 1'b0;
		port1_we   = 1'b0;
		port1_addr = '0;
		port1_mask = 2'b11;
		port1_d    = '0;
		port2_req  = 1'b0;
		port2_we   = 1'b0;
		port2_addr = '0;
		port2_mask = 2'b11;
		port2_d    = '0;
		rom_cs     = 1'b0;
		rom_addr   = '0;
		gfx_req    = 1'b0;
		gfx_addr   = '0;
		void'($urandom(SEED));
		build_table();
		preload_memory();
		repeat (RESET_CYCLES) @(negedge clk);
		init_n = 1'b1;
		repeat (POWER_UP_WAIT) @(negedge clk);
		power_up_order();
		for (int i = 0; i < NUM_STEPS; i++)
			apply_step(i);
		run_contention();
		idle_start = u_model.log_cmd.size();
		repeat (IDLE_CYCLES) @(negedge clk);
		refresh_spacing(idle_start);
		refresh_placement();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Watchdog against a request that never completes
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sdram_2ch.f ====
verilog/sdram_pkg.sv
verilog/sdram_chan_if.sv
verilog/sdram_slot_timer.sv
verilog/sdram_chan_arbiter.sv
verilog/sdram_cmd_seq.sv
verilog/sdram_2ch.sv
tb/sdram_model.sv
tb/tb_sdram_2ch.sv

// ==== Makefile ====
# Verilator build and run of the two-channel SDRAM controller testbench
# Any variable can be overridden on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_sdram_2ch
FILELIST  ?= sdram_2ch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and decide the result from the log
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
